/* filelist.f */
hw/fetch_pkg.sv
hw/refill_if.sv
hw/fetch_control.sv
hw/fetch_stats.sv
hw/icache_array.sv
hw/fetch_unit.sv
verification/fetch_unit_properties.sv
verification/fetch_unit_tb.sv

/* hw/fetch_control.sv */
`timescale 1ns/1ns

module fetch_control import fetch_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         npc_valid,
  input  word_t        npc,
  input  word_t        snpc,
  input  logic         idu_ready,
  input  logic         block,
  input  logic         clear_pipeline,
  output word_t        old_pc,
  output logic         inst_valid,
  output word_t        inst,
  output word_t        araddr,
  output logic         arvalid,
  output logic [7:0]   arlen,
  input  logic         arready,
  output logic         rready,
  input  word_t        rdata,
  input  logic         rvalid,
  input  logic         rlast,
  input  logic         hit,
  input  word_t        hit_word,
  output word_t        pc,
  output logic         busy,
  output logic         hit_step,
  output logic         miss_start,
  output logic         refill_busy,
  refill_if.controller refill
);

  fetch_state_t state;
  logic pipeline_empty; // No instruction delivered since reset or redirect
  logic step;
  logic guard;
  logic beat;
  logic req_sram;
  logic deliver;

  assign step = (state == fetch_lookup) && idu_ready && !block && !clear_pipeline;

  // Only start a memory read when the pc is known to be on the real path
  assign guard = pipeline_empty || (npc_valid && (snpc == pc));

  assign beat = (state == fetch_refill) && rready && rvalid;

  // The request address decides the kind of refill, since pc may be redirected meanwhile
  assign req_sram = (araddr[31:24] == sram_region);

  // An SRAM word is only handed on if it still belongs to the current pc
  assign deliver = beat && req_sram && (pc == araddr) && !clear_pipeline;

  assign hit_step = step && hit;
  assign miss_start = step && !hit && guard;
  assign refill_busy = (state == fetch_refill);
  assign busy = refill_busy;

  assign refill.fill_beat = beat && !req_sram;
  assign refill.fill_last = beat && !req_sram && rlast;
  assign refill.fill_data = rdata;
  assign refill.fill_index = araddr[offset_bits +: index_bits];
  assign refill.fill_tag = araddr[31 -: tag_bits];

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= fetch_lookup;
      pc <= reset_pc;
      arvalid <= 1'b0;
      rready <= 1'b0;
      inst_valid <= 1'b0;
      pipeline_empty <= 1'b1;
    end else begin
      if (clear_pipeline) begin
        pc <= npc;
        inst_valid <= 1'b0;
        pipeline_empty <= 1'b1;
      end else if (step) begin
        if (hit) begin
          inst_valid <= 1'b1;
          pc <= pc + 32'd4;
          pipeline_empty <= 1'b0;
        end else begin
          inst_valid <= 1'b0; // Dropped whether or not the miss may start
        end
      end else if (deliver) begin
        inst_valid <= 1'b1;
        pc <= pc + 32'd4;
        pipeline_empty <= 1'b0;
      end

      case (state)
        fetch_lookup: begin
          if (miss_start) begin
            state <= fetch_refill;
            arvalid <= 1'b1;
          end
        end
        fetch_refill: begin
          // The data channel opens in the cycle after the address beat
          if (arvalid && arready) begin
            arvalid <= 1'b0;
            rready <= 1'b1;
          end
          if (beat && rlast) begin
            rready <= 1'b0;
            state <= fetch_lookup;
          end
        end
        default: state <= fetch_lookup;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (miss_start) begin
      if (pc[31:24] == sram_region) begin
        araddr <= pc; // Exact word in a single beat
        arlen <= burst_len_single;
      end else begin
        araddr <= {pc[31:offset_bits], {offset_bits{1'b0}}};
        arlen <= burst_len_line;
      end
    end

    if (hit_step) begin
      inst <= hit_word;
      old_pc <= pc;
    end else if (deliver) begin
      inst <= rdata;
      old_pc <= pc;
    end
  end

endmodule

/* hw/fetch_pkg.sv */
package fetch_pkg;

  // Cache geometry of four lines of sixteen bytes
  localparam int offset_bits = 4;
  localparam int index_bits = 2;
  localparam int line_count = 4;
  localparam int tag_bits = 32 - offset_bits - index_bits;
  localparam int line_bits = 128;

  // AXI arlen values count the beats minus one
  localparam logic [7:0] burst_len_line = 8'd3;
  localparam logic [7:0] burst_len_single = 8'd0;

  // Address map
  localparam logic [31:0] reset_pc = 32'h3000_0000;
  localparam logic [7:0] sram_region = 8'h0f; // Top address byte of on-chip SRAM

  typedef enum logic {
    fetch_lookup,
    fetch_refill
  } fetch_state_t;

  typedef logic [tag_bits-1:0] cache_tag_t;

  typedef logic [index_bits-1:0] cache_index_t;

  typedef logic [31:0] word_t;

endpackage

/* hw/fetch_stats.sv */
`timescale 1ns/1ns

module fetch_stats (
  input  logic        clock,
  input  logic        reset,
  input  logic        hit_step,
  input  logic        miss_start,
  input  logic        refill_busy,
  output logic [31:0] hit_count,
  output logic [31:0] miss_count,
  output logic [31:0] refill_cycles
);

  // Counters stick at the top value instead of wrapping
  function automatic logic [31:0] sat_inc(input logic [31:0] value, input logic count_en);
    logic [31:0] result;
    result = value;
    if (count_en && (value != 32'hffff_ffff)) begin
      result = value + 32'd1;
    end
    return result;
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      hit_count <= 32'd0;
      miss_count <= 32'd0;
      refill_cycles <= 32'd0;
    end else begin
      hit_count <= sat_inc(hit_count, hit_step);
      miss_count <= sat_inc(miss_count, miss_start); // Misses that actually issued a read
      refill_cycles <= sat_inc(refill_cycles, refill_busy);
    end
  end

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit import fetch_pkg::*; (
  input  logic        clock,
  input  logic        reset,

  input  logic        npc_valid,
  input  word_t       npc,
  input  word_t       snpc,
  output word_t       old_pc,

  output logic        inst_valid,
  output word_t       inst,
  input  logic        idu_ready,
  input  logic        block,

  output logic        enable,
  output word_t       araddr,
  output logic        arvalid,
  output logic [7:0]  arlen,
  input  logic        arready,

  output logic        rready,
  input  word_t       rdata,
  input  logic [1:0]  rresp, // Response codes are not checked
  input  logic        rvalid,
  input  logic        rlast,
  input  logic        clear_cache,
  input  logic        clear_pipeline,

  output logic [31:0] hit_count,
  output logic [31:0] miss_count,
  output logic [31:0] refill_cycles
);

  word_t pc;
  logic hit;
  word_t hit_word;
  logic hit_step;
  logic miss_start;
  logic refill_busy;

  refill_if refill_bus ();

  fetch_control fetch_control_i (
    .clock          (clock),
    .reset          (reset),
    .npc_valid      (npc_valid),
    .npc            (npc),
    .snpc           (snpc),
    .idu_ready      (idu_ready),
    .block          (block),
    .clear_pipeline (clear_pipeline),
    .old_pc         (old_pc),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .araddr         (araddr),
    .arvalid        (arvalid),
    .arlen          (arlen),
    .arready        (arready),
    .rready         (rready),
    .rdata          (rdata),
    .rvalid         (rvalid),
    .rlast          (rlast),
    .hit            (hit),
    .hit_word       (hit_word),
    .pc             (pc),
    .busy           (enable),
    .hit_step       (hit_step),
    .miss_start     (miss_start),
    .refill_busy    (refill_busy),
    .refill         (refill_bus.controller)
  );

  icache_array icache_array_i (
    .clock       (clock),
    .reset       (reset),
    .clear_cache (clear_cache),
    .pc          (pc),
    .hit         (hit),
    .hit_word    (hit_word),
    .refill      (refill_bus.array)
  );

  fetch_stats fetch_stats_i (
    .clock         (clock),
    .reset         (reset),
    .hit_step      (hit_step),
    .miss_start    (miss_start),
    .refill_busy   (refill_busy),
    .hit_count     (hit_count),
    .miss_count    (miss_count),
    .refill_cycles (refill_cycles)
  );

endmodule

/* hw/icache_array.sv */
`timescale 1ns/1ns

module icache_array import fetch_pkg::*; (
  input  logic    clock,
  input  logic    reset,
  input  logic    clear_cache,
  input  word_t   pc,
  output logic    hit,
  output word_t   hit_word,
  refill_if.array refill
);

  logic [line_bits-1:0] line_data [line_count];
  cache_tag_t line_tag [line_count];
  logic [line_count-1:0] line_valid;

  cache_index_t index;
  cache_tag_t pc_tag;
  logic [offset_bits-3:0] word_sel;
  logic pc_sram;
  logic [line_bits-1:0] sel_line;

  assign index = pc[offset_bits +: index_bits];
  assign pc_tag = pc[31 -: tag_bits];
  assign word_sel = pc[offset_bits-1:2];
  assign pc_sram = (pc[31:24] == sram_region);

  assign sel_line = line_data[index];

  // SRAM addresses never hit, even if a matching tag happened to be present
  assign hit = line_valid[index] && (line_tag[index] == pc_tag) && !pc_sram;

  assign hit_word = sel_line[word_sel*32 +: 32];

  always_ff @(posedge clock) begin
    if (reset || clear_cache) begin
      line_valid <= '0;
    end else if (refill.fill_last) begin
      line_valid[refill.fill_index] <= 1'b1;
    end
  end

  // Beats arrive in address order and enter from the top of the line
  always_ff @(posedge clock) begin
    if (refill.fill_beat) begin
      line_data[refill.fill_index] <=
        {refill.fill_data, line_data[refill.fill_index][line_bits-1:32]};
    end
    if (refill.fill_last) begin
      line_tag[refill.fill_index] <= refill.fill_tag;
    end
  end

endmodule

/* hw/refill_if.sv */
`timescale 1ns/1ns

// Refill writes from the fetch controller into the cache array
interface refill_if import fetch_pkg::*; ();

  logic fill_beat; // One cycle per accepted read beat
  word_t fill_data;
  cache_index_t fill_index;
  cache_tag_t fill_tag;
  logic fill_last; // Final beat sets tag and valid

  modport controller (
    output fill_beat,
    output fill_data,
    output fill_index,
    output fill_tag,
    output fill_last
  );

  modport array (
    input fill_beat,
    input fill_data,
    input fill_index,
    input fill_tag,
    input fill_last
  );

endinterface

/* verification/fetch_input.txt */
# m <addr> <data> memory word in hex, other addresses read as a fill pattern
# r <count> <hits> <misses> consume count instructions, counter increases in decimal
# j <addr> redirect, f flush the cache, e <hits> <misses> expected final totals
m 30000000 00000413
m 30000004 00009117
m 30000008 ffc10113
m 3000000c 00c000ef
m 30000014 00100073
m 0f000100 00a00513
m 0f000108 00050463
r 8 8 2
j 30000000
r 8 8 0
j 0f000100
r 4 0 4
j 30000000
f
r 4 4 1
e 20 7

/* verification/fetch_unit_properties.sv */
`timescale 1ns/1ns

module fetch_unit_properties import fetch_pkg::*; (
  input logic       clock,
  input logic       reset,
  input logic       arvalid,
  input logic       arready,
  input logic       rready,
  input word_t      araddr,
  input logic [7:0] arlen,
  input logic       inst_valid,
  input logic       clear_pipeline
);

  int failures = 0;

  // An address beat stays offered until the slave takes it
  assert property (@(posedge clock) disable iff (reset) arvalid && !arready |=> arvalid)
    else begin
      $error("arvalid dropped before arready");
      failures++;
    end

  assert property (@(posedge clock) disable iff (reset) !(arvalid && rready))
    else begin
      $error("rready high while an address beat is pending");
      failures++;
    end

  assert property (@(posedge clock) disable iff (reset) clear_pipeline |=> !inst_valid)
    else begin
      $error("inst_valid high in the cycle after a redirect");
      failures++;
    end

  // Single beats for SRAM, full lines for everything else
  assert property (@(posedge clock) disable iff (reset)
    arvalid |-> ((arlen == burst_len_single) == (araddr[31:24] == sram_region)))
    else begin
      $error("arlen does not match the address region");
      failures++;
    end

endmodule

/* verification/fetch_unit_tb.sv */
`timescale 1ns/1ns

module fetch_unit_tb import fetch_pkg::*; ();

  logic clock = 1'b0;
  logic reset;
  logic npc_valid;
  word_t npc;
  word_t snpc;
  word_t old_pc;
  logic inst_valid;
  word_t inst;
  logic idu_ready;
  logic block;
  logic enable;
  word_t araddr;
  logic arvalid;
  logic [7:0] arlen;
  logic arready;
  logic rready;
  word_t rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rlast;
  logic clear_cache;
  logic clear_pipeline;
  logic [31:0] hit_count;
  logic [31:0] miss_count;
  logic [31:0] refill_cycles;

  word_t mem_image [word_t];
  logic [7:0] cmd_op [$];
  word_t cmd_a [$];
  word_t cmd_b [$];
  word_t cmd_c [$];

  word_t expect_pc; // Address of the next instruction to be consumed
  int run_total = 0;
  int timeout_limit = 0;
  int error_count = 0;
  int test_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int address_beats = 0;
  int line_refills = 0;

  fetch_unit fetch_unit_i (.*);

  bind fetch_control fetch_unit_properties fetch_unit_properties_i (
    .clock(clock), .reset(reset), .arvalid(arvalid), .arready(arready), .rready(rready),
    .araddr(araddr), .arlen(arlen), .inst_valid(inst_valid), .clear_pipeline(clear_pipeline)
  );

  always #20 clock = ~clock;

  function automatic word_t mem_word(input word_t addr);
    word_t value;
    if (mem_image.exists(addr)) value = mem_image[addr];
    else value = {addr[15:0], addr[31:16]} ^ 32'h5a3c_96e1; // Fill pattern
    return value;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t expected);
    if (got !== expected) begin
      $display("** Error: %s is %h, expected %h", name, got, expected);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("** Error: %s is %h, expected %h", name, got, expected);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("** Error: %s is %h, expected %h", name, got, expected);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic report_test(input string what);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d %s: ok", tests_run, what);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, what, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic load_program();
    int fd;
    int code;
    logic [15:0] tok;
    logic [8*128-1:0] rest;
    word_t a;
    word_t b;
    word_t c;
    fd = $fopen("verification/fetch_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open verification/fetch_input.txt");
      error_count++;
    end else begin
      code = $fscanf(fd, "%s", tok);
      while (code == 1) begin
        if (tok == "#") begin
          code = $fgets(rest, fd);
        end else if (tok == "m") begin
          code = $fscanf(fd, "%h %h", a, b);
          mem_image[a] = b;
        end else if (tok == "r" || tok == "e") begin
          code = (tok == "r") ? $fscanf(fd, "%d %d %d", a, b, c) : $fscanf(fd, "%d %d", a, b);
          if (tok == "r") run_total += a;
          cmd_op.push_back(tok[7:0]);
          cmd_a.push_back(a);
          cmd_b.push_back(b);
          cmd_c.push_back(c);
        end else if (tok == "j" || tok == "f") begin
          a = '0;
          if (tok == "j") code = $fscanf(fd, "%h", a);
          cmd_op.push_back(tok[7:0]);
          cmd_a.push_back(a);
          cmd_b.push_back('0);
          cmd_c.push_back('0);
        end else begin
          $display("Unknown command in the stimulus file");
          error_count++;
        end
        code = $fscanf(fd, "%s", tok);
      end
      $fclose(fd);
    end
  endtask

  task automatic run_instructions(input int count, input word_t hit_delta,
                                  input word_t miss_delta);
    logic [31:0] hits_before;
    logic [31:0] misses_before;
    int beats_before;
    int consumed;
    logic took;
    word_t start_pc;
    word_t taken_pc;
    hits_before = hit_count;
    misses_before = miss_count;
    beats_before = address_beats;
    start_pc = expect_pc;
    consumed = 0;
    taken_pc = '0;
    idu_ready = 1'b1;
    while (consumed < count) begin
      @(negedge clock);
      took = inst_valid && idu_ready && !block; // The coming edge consumes this one
      if (took) begin
        check_word("old_pc", old_pc, expect_pc);
        check_word("inst", inst, mem_word(expect_pc));
        taken_pc = old_pc;
        expect_pc = expect_pc + 32'd4;
        consumed++;
      end
      @(posedge clock);
      #5;
      if (took) begin
        npc_valid = 1'b1;
        snpc = taken_pc + 32'd4;
      end
      idu_ready = (consumed < count) ? (($urandom % 6) != 0) : 1'b0;
    end
    check_count("hit_count increase", hit_count - hits_before, hit_delta);
    check_count("miss_count increase", miss_count - misses_before, miss_delta);
    check_count("address beats", address_beats - beats_before, miss_delta);
    report_test($sformatf("run %0d from %h", count, start_pc));
  endtask

  task automatic redirect_to(input word_t target);
    idu_ready = 1'b0;
    npc = target;
    clear_pipeline = 1'b1;
    @(posedge clock);
    #5;
    clear_pipeline = 1'b0;
    expect_pc = target;
  endtask

  task automatic flush_cache();
    idu_ready = 1'b0;
    clear_cache = 1'b1;
    @(posedge clock);
    #5;
    clear_cache = 1'b0;
  endtask

  task automatic check_totals(input word_t hits, input word_t misses);
    check_count("hit_count", hit_count, hits);
    check_count("miss_count", miss_count, misses);
    if (refill_cycles < 4 * line_refills) begin
      $display("** Error: refill_cycles is %h, expected at least %h", refill_cycles,
               4 * line_refills);
      error_count++;
      test_errors++;
    end
    report_test("final counter totals");
  endtask

  // AXI read slave answering from the memory image
  initial begin : axi_slave
    int ar_delay;
    int beats_left;
    word_t beat_addr;
    logic ar_fire;
    logic r_fire;
    arready = 1'b0;
    rvalid = 1'b0;
    rlast = 1'b0;
    rdata = '0;
    rresp = 2'b00;
    ar_delay = -1;
    beats_left = 0;
    beat_addr = '0;
    forever begin
      @(negedge clock);
      ar_fire = arvalid && arready;
      r_fire = rvalid && rready;
      if (ar_fire) begin
        address_beats++;
        check_level("enable", enable, 1'b1);
        if (expect_pc[31:24] == sram_region) begin
          check_word("araddr", araddr, expect_pc);
          check_word("arlen", {24'h0, arlen}, {24'h0, burst_len_single});
        end else begin
          check_word("araddr", araddr, {expect_pc[31:offset_bits], {offset_bits{1'b0}}});
          check_word("arlen", {24'h0, arlen}, {24'h0, burst_len_line});
          line_refills++;
        end
        beat_addr = araddr;
        beats_left = arlen + 1;
      end
      if (r_fire) begin
        beat_addr = beat_addr + 32'd4;
        beats_left--;
      end
      @(posedge clock);
      #5;
      if (ar_fire) begin
        arready = 1'b0;
        ar_delay = -1;
      end else if (arvalid && !arready) begin
        if (ar_delay < 0) ar_delay = $urandom % 4;
        if (ar_delay == 0) arready = 1'b1;
        else ar_delay--;
      end
      if (beats_left == 0) begin
        rvalid = 1'b0;
        rlast = 1'b0;
      end else if (!rvalid || r_fire) begin
        rvalid = ($urandom % 4) != 0; // Random gaps between beats
        rdata = mem_word(beat_addr);
        rlast = rvalid && (beats_left == 1);
      end
    end
  end

  initial begin : watchdog
    int cycle_count;
    wait (timeout_limit > 0);
    cycle_count = 0;
    while (cycle_count < timeout_limit) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the fetch unit stopped delivering", cycle_count);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : main
    int seed;
    int seed_dummy;
    int i;
    int assert_failures;
    reset = 1'b1;
    npc_valid = 1'b0;
    npc = '0;
    snpc = '0;
    idu_ready = 1'b0;
    block = 1'b0;
    clear_cache = 1'b0;
    clear_pipeline = 1'b0;
    seed = 82;
    seed_dummy = $urandom(seed);
    expect_pc = reset_pc;
    load_program();
    timeout_limit = run_total * 40 + 200;
    repeat (4) @(posedge clock);
    #5;
    reset = 1'b0;

    check_level("arvalid", arvalid, 1'b0);
    check_level("inst_valid", inst_valid, 1'b0);
    check_level("enable", enable, 1'b0);
    check_count("hit_count", hit_count, 32'd0);
    check_count("miss_count", miss_count, 32'd0);
    check_count("refill_cycles", refill_cycles, 32'd0);
    report_test("reset state");

    for (i = 0; i < cmd_op.size(); i++) begin
      case (cmd_op[i])
        "r": run_instructions(cmd_a[i], cmd_b[i], cmd_c[i]);
        "j": redirect_to(cmd_a[i]);
        "f": flush_cache();
        "e": check_totals(cmd_a[i], cmd_b[i]);
        default: ;
      endcase
    end

    assert_failures = fetch_unit_i.fetch_control_i.fetch_unit_properties_i.failures;
    $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, error_count, assert_failures);
    if (error_count == 0 && assert_failures == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
